// File: design/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] regWord_t;
    typedef logic [4:0]  regIndex_t;
    typedef logic [31:0] instWord_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        wbNone,
        wbAlu,
        wbMem
    } wbSource_t;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // Function field of SPECIAL
    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSubu = 6'h23;
    localparam logic [5:0] functAnd  = 6'h24;
    localparam logic [5:0] functOr   = 6'h25;
    localparam logic [5:0] functSlt  = 6'h2a;

    typedef struct packed {
        logic      valid;
        regWord_t  pc;
        instWord_t instr;
    } decodeStage_t;

    typedef struct packed {
        logic      valid;
        regWord_t  pc;
        regWord_t  opA;
        regWord_t  opB;
        regWord_t  immediate;
        aluOp_t    aluOp;
        logic      aluImm;
        regIndex_t dest;
        wbSource_t wbSource;
        logic      isStore;
    } executeStage_t;

    typedef struct packed {
        logic      valid;
        regWord_t  pc;
        regWord_t  aluResult;
        regWord_t  storeData;
        regIndex_t dest;
        wbSource_t wbSource;
        logic      isStore;
    } memoryStage_t;

    typedef struct packed {
        logic      valid;
        regWord_t  pc;
        regWord_t  aluResult;
        regIndex_t dest;
        wbSource_t wbSource;
    } writebackStage_t;

endpackage

`default_nettype wire

// File: design/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
    parameter mipsPkg::regWord_t resetPc = 32'hBFC00000
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              hold,
    input  wire logic              redirect,
    input  wire mipsPkg::regWord_t redirectPc,
    output mipsPkg::regWord_t      pc
);
    import mipsPkg::*;

    // PC of the word arriving from the SRAM this cycle
    regWord_t currentPc;

    // Address issued now; its word arrives next cycle
    always_comb begin
        if (hold) begin
            pc = currentPc;
        end else if (redirect) begin
            pc = redirectPc;
        end else begin
            pc = currentPc + 32'd4;
        end
    end

    // Sits one word early so the first issued address is resetPc
    always_ff @(posedge clk) begin
        if (reset) begin
            currentPc <= resetPc - 32'd4;
        end else begin
            currentPc <= pc;
        end
    end

endmodule

`default_nettype wire

// File: design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire mipsPkg::instWord_t instr,
    output mipsPkg::regIndex_t      rs,
    output mipsPkg::regIndex_t      rt,
    output mipsPkg::regIndex_t      dest,
    output logic                    readRs,
    output logic                    readRt,
    output mipsPkg::regWord_t       immediate,
    output mipsPkg::aluOp_t         aluOp,
    output logic                    aluImm,
    output mipsPkg::wbSource_t      wbSource,
    output logic                    isStore,
    output logic                    isBeq,
    output logic                    isBne,
    output logic                    isJump,
    output logic [25:0]             jumpIndex
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regIndex_t  rd;

    assign opcode    = instr[31:26];
    assign funct     = instr[5:0];
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign rd        = instr[15:11];
    assign jumpIndex = instr[25:0];

    always_comb begin
        immediate = {{16{instr[15]}}, instr[15:0]};
        dest      = '0;
        readRs    = 1'b0;
        readRt    = 1'b0;
        aluOp     = aluAdd;
        aluImm    = 1'b1;
        wbSource  = wbNone;
        isStore   = 1'b0;
        isBeq     = 1'b0;
        isBne     = 1'b0;
        isJump    = 1'b0;
        case (opcode)
            opSpecial: begin
                readRs = 1'b1;
                readRt = 1'b1;
                aluImm = 1'b0;
                dest   = rd;
                wbSource = wbAlu;
                case (funct)
                    functAddu: aluOp = aluAdd;
                    functSubu: aluOp = aluSub;
                    functAnd:  aluOp = aluAnd;
                    functOr:   aluOp = aluOr;
                    functSlt:  aluOp = aluSlt;
                    default: begin
                        // Unknown function retires as a no-op
                        dest     = '0;
                        wbSource = wbNone;
                    end
                endcase
            end
            opAddiu: begin
                readRs   = 1'b1;
                dest     = rt;
                wbSource = wbAlu;
            end
            opOri: begin
                readRs    = 1'b1;
                dest      = rt;
                wbSource  = wbAlu;
                aluOp     = aluOr;
                immediate = {16'h0000, instr[15:0]};
            end
            opLui: begin
                dest      = rt;
                wbSource  = wbAlu;
                aluOp     = aluLui;
                immediate = {16'h0000, instr[15:0]};
            end
            opLw: begin
                readRs   = 1'b1;
                dest     = rt;
                wbSource = wbMem;
            end
            opSw: begin
                readRs  = 1'b1;
                readRt  = 1'b1;
                isStore = 1'b1;
            end
            opBeq: begin
                readRs = 1'b1;
                readRt = 1'b1;
                isBeq  = 1'b1;
            end
            opBne: begin
                readRs = 1'b1;
                readRt = 1'b1;
                isBne  = 1'b1;
            end
            opJ: isJump = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire mipsPkg::regIndex_t readIndexA,
    input  wire mipsPkg::regIndex_t readIndexB,
    output mipsPkg::regWord_t       readDataA,
    output mipsPkg::regWord_t       readDataB,
    input  wire mipsPkg::regIndex_t writeIndex,
    input  wire mipsPkg::regWord_t  writeData
);
    import mipsPkg::*;

    regWord_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    // Register zero never gets written, so it reads as zero
    assign readDataA = regs[readIndexA];
    assign readDataB = regs[readIndexB];

endmodule

`default_nettype wire

// File: design/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  wire mipsPkg::regWord_t opA,
    input  wire mipsPkg::regWord_t opB,
    input  wire mipsPkg::regWord_t immediate,
    input  wire logic              aluImm,
    input  wire mipsPkg::aluOp_t   aluOp,
    output mipsPkg::regWord_t      result
);
    import mipsPkg::*;

    regWord_t second;

    assign second = aluImm ? immediate : opB;

    always_comb begin
        case (aluOp)
            aluAdd:  result = opA + second;
            aluSub:  result = opA - second;
            aluAnd:  result = opA & second;
            aluOr:   result = opA | second;
            aluSlt:  result = {31'b0, $signed(opA) < $signed(second)};
            aluLui:  result = {second[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/stageRegister.sv
`timescale 1ns/1ps
`default_nettype none

module stageRegister #(
    parameter type payload_t = mipsPkg::decodeStage_t
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     hold,
    input  wire logic     flush,
    input  wire payload_t nextStage,
    output payload_t      stage
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // Bubble; the rest of the payload is don't care
            stage.valid <= 1'b0;
        end else if (!hold) begin
            stage <= nextStage;
        end
    end

endmodule

`default_nettype wire

// File: design/pipelineControl.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineControl (
    input  wire mipsPkg::regIndex_t rs,
    input  wire mipsPkg::regIndex_t rt,
    input  wire logic               readRs,
    input  wire logic               readRt,
    input  wire mipsPkg::regWord_t  fileA,
    input  wire mipsPkg::regWord_t  fileB,
    input  wire mipsPkg::regIndex_t exDest,
    input  wire mipsPkg::regIndex_t memDest,
    input  wire mipsPkg::regIndex_t wbDest,
    input  wire mipsPkg::wbSource_t exSource,
    input  wire mipsPkg::wbSource_t memSource,
    input  wire mipsPkg::wbSource_t wbSource,
    input  wire mipsPkg::regWord_t  memAlu,
    input  wire mipsPkg::regWord_t  wbData,
    input  wire logic               isBeq,
    input  wire logic               isBne,
    input  wire logic               isJump,
    input  wire logic [25:0]        jumpIndex,
    input  wire mipsPkg::regWord_t  immediate,
    input  wire mipsPkg::regWord_t  decodePc,
    output logic                    stallDecode,
    output logic                    redirect,
    output mipsPkg::regWord_t       redirectPc,
    output mipsPkg::regWord_t       operandA,
    output mipsPkg::regWord_t       operandB
);
    import mipsPkg::*;

    logic stallA;
    logic stallB;
    logic equal;
    logic taken;

    // Returns {stall, value} for one decode operand
    function automatic logic [32:0] resolve(input regIndex_t index, input logic read,
                                            input regWord_t fileValue);
        if (!read || index == '0) begin
            return {1'b0, fileValue};
        end
        if (exSource != wbNone && index == exDest) begin
            return {1'b1, fileValue};
        end
        if (memSource == wbMem && index == memDest) begin
            return {1'b1, fileValue};
        end
        if (memSource == wbAlu && index == memDest) begin
            return {1'b0, memAlu};
        end
        if (wbSource != wbNone && index == wbDest) begin
            return {1'b0, wbData};
        end
        return {1'b0, fileValue};
    endfunction

    always_comb begin
        {stallA, operandA} = resolve(rs, readRs, fileA);
        {stallB, operandB} = resolve(rt, readRt, fileB);
    end

    assign stallDecode = stallA || stallB;
    assign equal       = operandA == operandB;
    assign taken       = isJump || (isBeq && equal) || (isBne && !equal);
    assign redirect    = taken && !stallDecode;

    always_comb begin
        if (isJump) begin
            redirectPc = {decodePc[31:28], jumpIndex, 2'b00};
        end else begin
            redirectPc = decodePc + 32'd4 + {immediate[29:0], 2'b00};
        end
    end

endmodule

`default_nettype wire

// File: design/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter mipsPkg::regWord_t resetPc = 32'hBFC00000
) (
    input  wire logic              clk,
    input  wire logic              reset,
    output mipsPkg::regWord_t      instAddr,
    input  wire mipsPkg::regWord_t instRdata,
    output logic                   dataEn,
    output logic [3:0]             dataWen,
    output mipsPkg::regWord_t      dataAddr,
    output mipsPkg::regWord_t      dataWdata,
    input  wire mipsPkg::regWord_t dataRdata,
    output mipsPkg::regWord_t      debugWbPc,
    output logic [3:0]             debugWbRfWen,
    output mipsPkg::regIndex_t     debugWbRfWnum,
    output mipsPkg::regWord_t      debugWbRfWdata
);
    import mipsPkg::*;

    decodeStage_t    fetchOut, decodeStage;
    executeStage_t   decodeOut, executeStage;
    memoryStage_t    executeOut, memoryStage;
    writebackStage_t memoryOut, writebackStage;

    logic      fetchValid, stallDecode, redirect;
    regWord_t  redirectPc, issuedPc, fetchPc;
    instWord_t decodeInstr;
    regIndex_t rs, rt, dest, wbIndex;
    logic      readRs, readRt, aluImm, isStore, isBeq, isBne, isJump;
    regWord_t  immediate, fileA, fileB, operandA, operandB, aluResult, wbData;
    aluOp_t    aluOp;
    wbSource_t wbSource;
    logic [25:0] jumpIndex;

    fetchUnit #(.resetPc(resetPc)) fetch (
        .clk(clk), .reset(reset), .hold(stallDecode), .redirect(redirect),
        .redirectPc(redirectPc), .pc(issuedPc)
    );

    assign instAddr = issuedPc;

    // The word on instRdata belongs to last cycle's address
    always_ff @(posedge clk) begin
        if (reset) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= 1'b1;
        end
        fetchPc <= issuedPc;
    end

    assign fetchOut = '{valid: fetchValid, pc: fetchPc, instr: instRdata};

    stageRegister #(.payload_t(decodeStage_t)) decodeLatch (
        .clk(clk), .reset(reset), .hold(stallDecode), .flush(1'b0),
        .nextStage(fetchOut), .stage(decodeStage)
    );

    // A bubble decodes as an all-zero word, which does nothing
    assign decodeInstr = decodeStage.valid ? decodeStage.instr : '0;

    instrDecoder decoder (
        .instr(decodeInstr), .rs(rs), .rt(rt), .dest(dest), .readRs(readRs), .readRt(readRt),
        .immediate(immediate), .aluOp(aluOp), .aluImm(aluImm), .wbSource(wbSource),
        .isStore(isStore), .isBeq(isBeq), .isBne(isBne), .isJump(isJump),
        .jumpIndex(jumpIndex)
    );

    registerFile regFile (
        .clk(clk), .reset(reset), .readIndexA(rs), .readIndexB(rt),
        .readDataA(fileA), .readDataB(fileB), .writeIndex(wbIndex), .writeData(wbData)
    );

    pipelineControl control (
        .rs(rs), .rt(rt), .readRs(readRs), .readRt(readRt), .fileA(fileA), .fileB(fileB),
        .exDest(executeStage.dest), .memDest(memoryStage.dest), .wbDest(wbIndex),
        .exSource(executeStage.valid ? executeStage.wbSource : wbNone),
        .memSource(memoryStage.valid ? memoryStage.wbSource : wbNone),
        .wbSource(writebackStage.valid ? writebackStage.wbSource : wbNone),
        .memAlu(memoryStage.aluResult), .wbData(wbData),
        .isBeq(isBeq), .isBne(isBne), .isJump(isJump), .jumpIndex(jumpIndex),
        .immediate(immediate), .decodePc(decodeStage.pc),
        .stallDecode(stallDecode), .redirect(redirect), .redirectPc(redirectPc),
        .operandA(operandA), .operandB(operandB)
    );

    assign decodeOut = '{valid: decodeStage.valid, pc: decodeStage.pc, opA: operandA,
                         opB: operandB, immediate: immediate, aluOp: aluOp, aluImm: aluImm,
                         dest: dest, wbSource: wbSource, isStore: isStore};

    stageRegister #(.payload_t(executeStage_t)) executeLatch (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(stallDecode),
        .nextStage(decodeOut), .stage(executeStage)
    );

    executeUnit alu (
        .opA(executeStage.opA), .opB(executeStage.opB), .immediate(executeStage.immediate),
        .aluImm(executeStage.aluImm), .aluOp(executeStage.aluOp), .result(aluResult)
    );

    assign executeOut = '{valid: executeStage.valid, pc: executeStage.pc,
                          aluResult: aluResult, storeData: executeStage.opB,
                          dest: executeStage.dest, wbSource: executeStage.wbSource,
                          isStore: executeStage.isStore};

    stageRegister #(.payload_t(memoryStage_t)) memoryLatch (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(1'b0),
        .nextStage(executeOut), .stage(memoryStage)
    );

    assign dataEn = memoryStage.valid && (memoryStage.isStore || memoryStage.wbSource == wbMem);
    assign dataWen = {4{memoryStage.valid && memoryStage.isStore}};
    assign dataAddr = {memoryStage.aluResult[31:2], 2'b00};
    assign dataWdata = memoryStage.storeData;

    assign memoryOut = '{valid: memoryStage.valid, pc: memoryStage.pc,
                         aluResult: memoryStage.aluResult, dest: memoryStage.dest,
                         wbSource: memoryStage.wbSource};

    stageRegister #(.payload_t(writebackStage_t)) writebackLatch (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(1'b0),
        .nextStage(memoryOut), .stage(writebackStage)
    );

    assign wbData = writebackStage.wbSource == wbMem ? dataRdata : writebackStage.aluResult;
    // Index zero means no write this cycle
    assign wbIndex = (writebackStage.valid && writebackStage.wbSource != wbNone) ?
                     writebackStage.dest : '0;

    assign debugWbPc      = writebackStage.pc;
    assign debugWbRfWen   = {4{wbIndex != '0}};
    assign debugWbRfWnum  = wbIndex;
    assign debugWbRfWdata = wbData;

endmodule

`default_nettype wire

// File: verif/mipsCore_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore_checker (
    input wire logic               clk,
    input wire logic               reset,
    input wire mipsPkg::regWord_t  instAddr,
    input wire logic               dataEn,
    input wire logic [3:0]         dataWen,
    input wire logic [3:0]         debugWbRfWen,
    input wire mipsPkg::regIndex_t debugWbRfWnum
);

    storeHasEnable: assert property (@(posedge clk) disable iff (reset)
        dataWen != 4'b0000 |-> dataEn)
        else $error("dataWen is set while dataEn is low");

    // Trace write enable is all or nothing
    wenAllOrNone: assert property (@(posedge clk) disable iff (reset)
        debugWbRfWen == 4'b0000 || debugWbRfWen == 4'b1111)
        else $error("debugWbRfWen is partially set");

    noWriteToZero: assert property (@(posedge clk) disable iff (reset)
        debugWbRfWen != 4'b0000 |-> debugWbRfWnum != '0)
        else $error("Trace reports a write to register zero");

    fetchAddrKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(instAddr))
        else $error("instAddr has unknown bits");

endmodule

bind mipsCore mipsCore_checker portCheck (
    .clk(clk),
    .reset(reset),
    .instAddr(instAddr),
    .dataEn(dataEn),
    .dataWen(dataWen),
    .debugWbRfWen(debugWbRfWen),
    .debugWbRfWnum(debugWbRfWnum)
);

`default_nettype wire

// File: verif/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
    import mipsPkg::*;

    localparam regWord_t resetPc = 32'hBFC00000;
    localparam int resetCycles = 10;
    localparam int programWords = 24;
    localparam int drainCycles = 20;
    // Reset, four cycles per program word, then slack; 4 ns per cycle
    localparam int timeoutNs = (resetCycles + 4 * programWords + 20) * 4;

    logic       clk;
    logic       reset;
    regWord_t   instAddr;
    regWord_t   instRdata;
    logic       dataEn;
    logic [3:0] dataWen;
    regWord_t   dataAddr;
    regWord_t   dataWdata;
    regWord_t   dataRdata;
    regWord_t   debugWbPc;
    logic [3:0] debugWbRfWen;
    regIndex_t  debugWbRfWnum;
    regWord_t   debugWbRfWdata;

    instWord_t programMem [32];
    regWord_t  dataMem [64];
    int        expPcIndex [$];
    regIndex_t expReg [$];
    regWord_t  expValue [$];
    int        errors;
    int        matched;
    int        dataAccesses;

    // Requests seen in the cycle before the SRAMs answer
    regWord_t   fetchAddr;
    logic       memEn;
    logic [3:0] memWen;
    regWord_t   memAddr;
    regWord_t   memWdata;

    mipsCore #(.resetPc(resetPc)) UUT (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instRdata(instRdata),
        .dataEn(dataEn),
        .dataWen(dataWen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .debugWbPc(debugWbPc),
        .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum),
        .debugWbRfWdata(debugWbRfWdata)
    );

    function automatic instWord_t iType(input logic [5:0] op, input int rs, input int rt,
                                        input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic instWord_t rType(input int rs, input int rt, input int rd,
                                        input logic [5:0] funct);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'h00, funct};
    endfunction

    function automatic instWord_t jType(input regWord_t target);
        return {6'h02, target[27:2]};
    endfunction

    function automatic instWord_t fetchWord(input regWord_t addr);
        regWord_t offset;
        offset = addr - resetPc;
        if (offset < 32'd128) begin
            return programMem[offset[6:2]];
        end
        return '0;
    endfunction

    task automatic addExpected(input int pcIndex, input int regNum, input regWord_t value);
        expPcIndex.push_back(pcIndex);
        expReg.push_back(regNum[4:0]);
        expValue.push_back(value);
    endtask

    task automatic checkWord(input string name, input regWord_t actual,
                             input regWord_t expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic checkIndex(input string name, input regIndex_t actual,
                              input regIndex_t expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED time %0t: %s is %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 32; i++) begin
            programMem[i] = '0;
        end
        programMem[0]  = iType(6'h09, 0, 1, 16'd5);
        programMem[1]  = iType(6'h0d, 0, 2, 16'h00F0);
        programMem[2]  = iType(6'h0f, 0, 3, 16'h1234);
        // Dependency chain at distances 3, 2 and 1
        programMem[3]  = rType(1, 2, 4, 6'h21);
        programMem[4]  = rType(4, 1, 5, 6'h23);
        programMem[5]  = rType(5, 2, 6, 6'h24);
        programMem[6]  = rType(6, 3, 7, 6'h25);
        programMem[7]  = iType(6'h09, 0, 8, 16'hFFFF);
        programMem[8]  = rType(8, 1, 9, 6'h2a);
        programMem[9]  = rType(1, 8, 10, 6'h2a);
        // Store, load back, then use right away
        programMem[10] = iType(6'h2b, 0, 7, 16'd16);
        programMem[11] = iType(6'h23, 0, 11, 16'd16);
        programMem[12] = rType(11, 1, 12, 6'h21);
        // beq taken to word 16, word 15 skipped
        programMem[13] = iType(6'h04, 1, 1, 16'd2);
        programMem[14] = iType(6'h09, 0, 13, 16'd7);
        programMem[15] = iType(6'h09, 0, 14, 16'd99);
        programMem[16] = iType(6'h05, 1, 1, 16'd2);
        programMem[17] = iType(6'h09, 0, 15, 16'd8);
        programMem[18] = iType(6'h09, 0, 16, 16'd9);
        // j to word 22, word 21 skipped
        programMem[19] = jType(resetPc + 32'd88);
        programMem[20] = iType(6'h09, 0, 17, 16'd10);
        programMem[21] = iType(6'h09, 0, 18, 16'd11);
        programMem[22] = rType(16, 17, 19, 6'h21);
        programMem[23] = iType(6'h09, 19, 20, 16'd1);
    endtask

    task automatic loadExpected();
        addExpected(0, 1, 32'd5);
        addExpected(1, 2, 32'h000000F0);
        addExpected(2, 3, 32'h12340000);
        addExpected(3, 4, 32'h000000F5);
        addExpected(4, 5, 32'h000000F0);
        addExpected(5, 6, 32'h000000F0);
        addExpected(6, 7, 32'h123400F0);
        addExpected(7, 8, 32'hFFFFFFFF);
        addExpected(8, 9, 32'd1);
        addExpected(9, 10, 32'd0);
        addExpected(11, 11, 32'h123400F0);
        addExpected(12, 12, 32'h123400F5);
        addExpected(14, 13, 32'd7);
        addExpected(17, 15, 32'd8);
        addExpected(18, 16, 32'd9);
        addExpected(20, 17, 32'd10);
        addExpected(22, 19, 32'd19);
        addExpected(23, 20, 32'd20);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Both SRAMs answer one cycle after the request
    always begin
        @(negedge clk);
        fetchAddr = instAddr;
        memEn = dataEn;
        memWen = dataWen;
        memAddr = dataAddr;
        memWdata = dataWdata;
        @(posedge clk);
        #1;
        instRdata = fetchWord(fetchAddr);
        if (memWen != 4'b0000) begin
            dataMem[memAddr[7:2]] = memWdata;
        end else if (memEn) begin
            dataRdata = dataMem[memAddr[7:2]];
        end
    end

    always @(negedge clk) begin
        if (reset && (dataEn || dataWen != 4'b0000 || debugWbRfWen != 4'b0000)) begin
            errors++;
            $display("Data or writeback strobe active during reset at time %0t", $time);
        end
    end

    // The program's one store and one load both use byte address 16
    always @(negedge clk) begin
        if (!reset && dataEn) begin
            dataAccesses++;
            checkWord("dataAddr", dataAddr, 32'd16);
        end
    end

    initial begin
        int row;
        reset = 1'b1;
        instRdata = '0;
        dataRdata = '0;
        errors = 0;
        matched = 0;
        dataAccesses = 0;
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = '0;
        end
        loadProgram();
        loadExpected();
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
        for (row = 0; row < expValue.size(); row++) begin
            do begin
                @(negedge clk);
            end while (debugWbRfWen == 4'b0000);
            checkWord("debugWbPc", debugWbPc, resetPc + 32'(4 * expPcIndex[row]));
            checkIndex("debugWbRfWnum", debugWbRfWnum, expReg[row]);
            checkWord("debugWbRfWdata", debugWbRfWdata, expValue[row]);
            matched++;
        end
        // Past the program only no-ops remain
        repeat (drainCycles) begin
            @(negedge clk);
            if (debugWbRfWen != 4'b0000) begin
                errors++;
                $display("Unexpected extra writeback to register %0d from PC %h",
                         debugWbRfWnum, debugWbPc);
            end
        end
        if (dataAccesses != 2) begin
            errors++;
            $display("Expected 2 data accesses but saw %0d", dataAccesses);
        end
        $display("Matched %0d of %0d writebacks, %0d errors", matched, expValue.size(), errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout after %0d ns, only %0d of %0d writebacks seen",
                 timeoutNs, matched, expValue.size());
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mipsCore.f
design/mipsPkg.sv
design/fetchUnit.sv
design/instrDecoder.sv
design/registerFile.sv
design/executeUnit.sv
design/stageRegister.sv
design/pipelineControl.sv
design/mipsCore.sv
verif/mipsCore_checker.sv
verif/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mipsCore.f --top-module mipsCoreTb -o VmipsCoreTb

./obj_dir/VmipsCoreTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
